// ==== design/tcb_pkg.sv ====
/*
  shared TCB widths and types for the two-port memory subsystem
  addresses are byte addresses, word aligned (low two bits zero)
  response delay is fixed, no other delay is supported
*/

package tcb_pkg;

  //////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////

  // byte address width
  localparam int unsigned ADR_W = 10;
  // data word width
  localparam int unsigned DAT_W = 32;
  // byte lanes per word
  localparam int unsigned BEN_W = DAT_W / 8;

  // cycles from accepted request to response
  localparam int unsigned RSP_DLY = 1;

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  // byte address, low two bits must be zero
  typedef logic [ADR_W-1:0] adr_t;
  // data word
  typedef logic [DAT_W-1:0] dat_t;
  // byte enables, one per lane
  typedef logic [BEN_W-1:0] ben_t;

  // which port got the last grant
  typedef enum logic {
    own_p0,
    own_p1
  } arb_owner_e;

endpackage

// ==== design/tcb_if.sv ====
/*
  TCB point-to-point link, no clock inside
  transfer when vld and rdy are both high
  response signals valid RSP_DLY cycles after the transfer
*/

`timescale 1ns/100ps

interface tcb_if;
  import tcb_pkg::*;

  // request, manager side
  logic vld;
  logic wen;
  adr_t adr;
  ben_t ben;
  dat_t wdt;

  // handshake and response, subordinate side
  logic rdy;
  dat_t rdt;
  logic err;
  logic rsp_vld;

  // manager drives the request
  modport man (
    output vld, wen, adr, ben, wdt,
    input  rdy, rdt, err, rsp_vld
  );

  // subordinate drives ready and response
  modport sub (
    input  vld, wen, adr, ben, wdt,
    output rdy, rdt, err, rsp_vld
  );

endinterface

// ==== design/tcb_arbiter.sv ====
/*
  round-robin arbiter, two TCB managers onto one subordinate
  grant and rdy are combinational, port 0 wins the first contest
  writes from a port with WR_MASK bit clear reach memory with no lanes
  and return err high, response is routed to the issuing port
*/

`timescale 1ns/100ps

module tcb_arbiter #(
  parameter logic [1:0] WR_MASK = 2'b01
) (
  input  logic tcb_clk,
  input  logic rst_n,
  tcb_if.sub   man_p0,
  tcb_if.sub   man_p1,
  tcb_if.man   sub
);
  import tcb_pkg::*;

  arb_owner_e last_own;  // last granted port
  arb_owner_e sel;       // port granted this cycle
  arb_owner_e rsp_own;   // owner of the response in flight
  logic       rsp_err;   // in-flight response is a masked write
  logic       masked;    // selected request is a forbidden write
  logic       trn;

  //////////////////////////////////////////////////
  // grant
  //////////////////////////////////////////////////

  // single requester wins, on a tie the one that did not own last
  always_comb begin
    if (man_p0.vld && man_p1.vld) begin
      sel = (last_own == own_p0) ? own_p1 : own_p0;
    end else if (man_p1.vld) begin
      sel = own_p1;
    end else begin
      sel = own_p0;
    end
  end

  // request mux toward memory
  always_comb begin
    sub.vld = man_p0.vld | man_p1.vld;
    if (sel == own_p1) begin
      sub.wen = man_p1.wen;
      sub.adr = man_p1.adr;
      sub.wdt = man_p1.wdt;
      masked  = man_p1.wen & ~WR_MASK[1];
      // forbidden write keeps memory as it is
      sub.ben = masked ? '0 : man_p1.ben;
    end else begin
      sub.wen = man_p0.wen;
      sub.adr = man_p0.adr;
      sub.wdt = man_p0.wdt;
      masked  = man_p0.wen & ~WR_MASK[0];
      sub.ben = masked ? '0 : man_p0.ben;
    end
  end

  // loser sees rdy low and holds
  assign man_p0.rdy = sub.rdy & (sel == own_p0);
  assign man_p1.rdy = sub.rdy & (sel == own_p1);

  assign trn = sub.vld & sub.rdy;

  //////////////////////////////////////////////////
  // owner and response tracking
  //////////////////////////////////////////////////

  always_ff @(posedge tcb_clk or negedge rst_n) begin
    if (!rst_n) begin
      last_own <= own_p1;
      rsp_own  <= own_p0;
      rsp_err  <= 1'b0;
    end else if (trn) begin
      last_own <= sel;
      rsp_own  <= sel;
      rsp_err  <= masked;
    end
  end

  // steer memory response to the issuing port
  assign man_p0.rsp_vld = sub.rsp_vld & (rsp_own == own_p0);
  assign man_p1.rsp_vld = sub.rsp_vld & (rsp_own == own_p1);
  assign man_p0.rdt     = (rsp_own == own_p0) ? sub.rdt : '0;
  assign man_p1.rdt     = (rsp_own == own_p1) ? sub.rdt : '0;
  assign man_p0.err     = man_p0.rsp_vld & (rsp_err | sub.err);
  assign man_p1.err     = man_p1.rsp_vld & (rsp_err | sub.err);

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // memory answers exactly RSP_DLY after each transfer
  a_rsp_dly: assert property (@(posedge tcb_clk) disable iff (!rst_n)
    sub.rsp_vld |-> $past(trn, RSP_DLY));

  // stalled request gets the grant in the next cycle
  a_gnt_hold_p0: assert property (@(posedge tcb_clk) disable iff (!rst_n)
    (man_p0.vld && !man_p0.rdy) |=> (!man_p0.vld || man_p0.rdy));

  a_gnt_hold_p1: assert property (@(posedge tcb_clk) disable iff (!rst_n)
    (man_p1.vld && !man_p1.rdy) |=> (!man_p1.vld || man_p1.rdy));

endmodule

// ==== design/tcb_memory.sv ====
/*
  single-port word memory behind a TCB subordinate
  rdy always high, read data registered one cycle after the transfer
  disabled lanes read as zero, write responses carry zero data
  no reset on the array, contents are undefined until written
*/

`timescale 1ns/100ps

module tcb_memory #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic tcb_clk,
  input  logic rst_n,
  tcb_if.sub   bus
);
  import tcb_pkg::*;

  dat_t             mem [MEM_WORDS];
  logic [ADR_W-3:0] idx;       // word index
  dat_t             lane_msk;  // byte enables widened to bits
  dat_t             rdt_q;
  logic             rsp_q;
  logic             trn;

  // depth must fit the address space
  if (MEM_WORDS > 2 ** (ADR_W - 2)) begin : g_depth_chk
    $error("MEM_WORDS exceeds the address range");
  end

  assign idx = bus.adr[ADR_W-1:2];
  assign trn = bus.vld & bus.rdy;

  // one byte of mask per enabled lane
  always_comb begin
    for (int b = 0; b < BEN_W; b++) begin
      lane_msk[8*b +: 8] = {8{bus.ben[b]}};
    end
  end

  //////////////////////////////////////////////////
  // array access
  //////////////////////////////////////////////////

  // lane-wise write
  always_ff @(posedge tcb_clk) begin
    if (trn && bus.wen) begin
      for (int b = 0; b < BEN_W; b++) begin
        if (bus.ben[b]) begin
          mem[idx][8*b +: 8] <= bus.wdt[8*b +: 8];
        end
      end
    end
  end

  // registered read data
  always_ff @(posedge tcb_clk) begin
    if (trn) begin
      rdt_q <= bus.wen ? '0 : (mem[idx] & lane_msk);
    end
  end

  // response strobe follows the transfer
  always_ff @(posedge tcb_clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_q <= 1'b0;
    end else begin
      rsp_q <= trn;
    end
  end

  assign bus.rdy     = 1'b1;
  assign bus.rdt     = rdt_q;
  assign bus.rsp_vld = rsp_q;
  assign bus.err     = 1'b0;

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  a_align: assert property (@(posedge tcb_clk) disable iff (!rst_n)
    trn |-> (bus.adr[1:0] == 2'b00));

  a_range: assert property (@(posedge tcb_clk) disable iff (!rst_n)
    trn |-> (int'(idx) < MEM_WORDS));

endmodule

// ==== design/tcb_mem_subsys.sv ====
/*
  two-port TCB memory subsystem, plain ports per manager
  WR_MASK bit i enables writes from port i
  each accepted request answers on its own port one cycle later
*/

`timescale 1ns/100ps

module tcb_mem_subsys #(
  parameter logic [1:0]  WR_MASK   = 2'b01,
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic           tcb_clk,
  input  logic           rst_n,
  // port 0
  input  logic           p0_vld,
  input  logic           p0_wen,
  input  tcb_pkg::adr_t  p0_adr,
  input  tcb_pkg::ben_t  p0_ben,
  input  tcb_pkg::dat_t  p0_wdt,
  output logic           p0_rdy,
  output tcb_pkg::dat_t  p0_rdt,
  output logic           p0_err,
  output logic           p0_rsp_vld,
  // port 1
  input  logic           p1_vld,
  input  logic           p1_wen,
  input  tcb_pkg::adr_t  p1_adr,
  input  tcb_pkg::ben_t  p1_ben,
  input  tcb_pkg::dat_t  p1_wdt,
  output logic           p1_rdy,
  output tcb_pkg::dat_t  p1_rdt,
  output logic           p1_err,
  output logic           p1_rsp_vld
);

  tcb_if p0_bus ();
  tcb_if p1_bus ();
  tcb_if mem_bus ();

  // port 0 onto its link
  assign p0_bus.vld = p0_vld;
  assign p0_bus.wen = p0_wen;
  assign p0_bus.adr = p0_adr;
  assign p0_bus.ben = p0_ben;
  assign p0_bus.wdt = p0_wdt;
  assign p0_rdy     = p0_bus.rdy;
  assign p0_rdt     = p0_bus.rdt;
  assign p0_err     = p0_bus.err;
  assign p0_rsp_vld = p0_bus.rsp_vld;

  // port 1 onto its link
  assign p1_bus.vld = p1_vld;
  assign p1_bus.wen = p1_wen;
  assign p1_bus.adr = p1_adr;
  assign p1_bus.ben = p1_ben;
  assign p1_bus.wdt = p1_wdt;
  assign p1_rdy     = p1_bus.rdy;
  assign p1_rdt     = p1_bus.rdt;
  assign p1_err     = p1_bus.err;
  assign p1_rsp_vld = p1_bus.rsp_vld;

  tcb_arbiter #(
    .WR_MASK (WR_MASK)
  ) arbiter_i (
    .tcb_clk (tcb_clk),
    .rst_n   (rst_n),
    .man_p0  (p0_bus),
    .man_p1  (p1_bus),
    .sub     (mem_bus)
  );

  tcb_memory #(
    .MEM_WORDS (MEM_WORDS)
  ) memory_i (
    .tcb_clk (tcb_clk),
    .rst_n   (rst_n),
    .bus     (mem_bus)
  );

endmodule

// ==== verification/tb_clock.sv ====
/*
  free-running tcb clock and active-low reset for the testbench
  reset is released on a falling edge after RST_CYCLES periods
*/

`timescale 1ns/100ps

module tb_clock #(
  parameter int HALF_NS    = 10,
  parameter int RST_CYCLES = 8
) (
  output logic tcb_clk,
  output logic rst_n
);

  // 20 ns period with the defaults
  initial begin
    tcb_clk = 1'b0;
    forever #(HALF_NS) tcb_clk = ~tcb_clk;
  end

  // held low for full periods
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(negedge tcb_clk);
    rst_n = 1'b1;
  end

endmodule

// ==== verification/tb_tcb_mem_subsys.sv ====
/*
  testbench for the two-port TCB memory subsystem, default parameters
  port 1 is read-only, no word is read before it is written
  rows with both ports valid must use different word addresses
*/

`timescale 1ns/100ps

module tb_tcb_mem_subsys;
  import tcb_pkg::*;

  // one request of a table row and its expected response
  typedef struct packed {
    logic vld;
    logic wen;
    adr_t adr;
    ben_t ben;
    dat_t wdt;
    dat_t exp_rdt;
    logic exp_err;
  } req_t;

  localparam logic [1:0]  WR_MASK = 2'b01;
  localparam int unsigned N_RND   = 16;
  localparam req_t        IDLE    = '0;

  logic tcb_clk, rst_n;
  logic p0_vld, p0_wen, p0_rdy, p0_err, p0_rsp_vld;
  logic p1_vld, p1_wen, p1_rdy, p1_err, p1_rsp_vld;
  adr_t p0_adr, p1_adr;
  ben_t p0_ben, p1_ben;
  dat_t p0_wdt, p1_wdt, p0_rdt, p1_rdt;

  dat_t        shadow [2 ** (ADR_W - 2)];
  req_t        row_p0 [$];
  req_t        row_p1 [$];
  adr_t        rnd_adr [N_RND];
  logic [7:0]  rnd_base;
  int          seed = 61884;
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit = 0;
  arb_owner_e  exp_last;

  tb_clock clock_i (
    .tcb_clk (tcb_clk),
    .rst_n   (rst_n)
  );

  tcb_mem_subsys tcb_mem_subsys_i (.*);

  //////////////////////////////////////////////////
  // reporting
  //////////////////////////////////////////////////

  task automatic stop_with_failure(string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(string name, dat_t exp, dat_t act);
    assert (act === exp) else begin
      stop_with_failure($sformatf("[FAIL] %s expected 0x%0h got 0x%0h", name, exp, act));
    end
  endtask

  // run limit, 4 cycles per row plus reset and margin
  always @(posedge tcb_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      stop_with_failure($sformatf("timeout after %0d cycles, table not finished", cycle_cnt));
    end
  end

  //////////////////////////////////////////////////
  // table building with the shadow memory
  //////////////////////////////////////////////////

  function automatic dat_t lane_mask(ben_t ben);
    dat_t m;
    for (int b = 0; b < BEN_W; b++) begin
      m[8*b +: 8] = {8{ben[b]}};
    end
    return m;
  endfunction

  // expected response from port rules, shadow follows the writes
  function automatic req_t build_req(int p, logic wen, adr_t adr, ben_t ben, dat_t wdt);
    req_t r;
    dat_t m;
    logic wr_ok;
    r     = IDLE;
    r.vld = 1'b1;
    r.wen = wen;
    r.adr = adr;
    r.ben = ben;
    r.wdt = wdt;
    m     = lane_mask(ben);
    wr_ok = (p == 0) ? WR_MASK[0] : WR_MASK[1];
    if (wen && wr_ok) begin
      shadow[adr[ADR_W-1:2]] = (shadow[adr[ADR_W-1:2]] & ~m) | (wdt & m);
    end else if (wen) begin
      // read-only port, word stays as it was
      r.exp_err = 1'b1;
    end else begin
      // lanes not enabled come back as zero
      r.exp_rdt = shadow[adr[ADR_W-1:2]] & m;
    end
    return r;
  endfunction

  function automatic req_t read_req(int p, adr_t adr, ben_t ben);
    return build_req(p, 1'b0, adr, ben, '0);
  endfunction

  function automatic req_t write_req(int p, adr_t adr, ben_t ben, dat_t wdt);
    return build_req(p, 1'b1, adr, ben, wdt);
  endfunction

  task automatic add_row(req_t r0, req_t r1);
    row_p0.push_back(r0);
    row_p1.push_back(r1);
  endtask

  //////////////////////////////////////////////////
  // driving and checking
  //////////////////////////////////////////////////

  task automatic drive_req(int p, req_t r);
    if (p == 0) begin
      p0_vld = r.vld;
      p0_wen = r.wen;
      p0_adr = r.adr;
      p0_ben = r.ben;
      p0_wdt = r.wdt;
    end else begin
      p1_vld = r.vld;
      p1_wen = r.wen;
      p1_adr = r.adr;
      p1_ben = r.ben;
      p1_wdt = r.wdt;
    end
  endtask

  // response only on the issuing port, one cycle after its transfer
  task automatic check_rsp(int p, logic acc, req_t r);
    logic vld;
    logic err;
    dat_t rdt;
    vld = (p == 0) ? p0_rsp_vld : p1_rsp_vld;
    err = (p == 0) ? p0_err : p1_err;
    rdt = (p == 0) ? p0_rdt : p1_rdt;
    check_value($sformatf("p%0d_rsp_vld", p), dat_t'(acc), dat_t'(vld));
    check_value($sformatf("p%0d_err", p), dat_t'(acc & r.exp_err), dat_t'(err));
    if (acc) begin
      check_value($sformatf("p%0d_rdt", p), r.exp_rdt, rdt);
    end
  endtask

  // hold the row until every valid request has seen rdy
  task automatic apply_row(int n);
    logic pend0, pend1, acc0, acc1, win0;
    drive_req(0, row_p0[n]);
    drive_req(1, row_p1[n]);
    pend0 = row_p0[n].vld;
    pend1 = row_p1[n].vld;
    do begin
      @(posedge tcb_clk);
      acc0 = pend0 & p0_rdy;
      acc1 = pend1 & p1_rdy;
      // tie goes to the port that did not own the last grant
      win0 = (pend0 && pend1) ? (exp_last == own_p1) : pend0;
      if (pend0) check_value("p0_rdy", dat_t'(win0), dat_t'(p0_rdy));
      if (pend1) check_value("p1_rdy", dat_t'(!win0), dat_t'(p1_rdy));
      if (acc0) exp_last = own_p0;
      if (acc1) exp_last = own_p1;
      @(negedge tcb_clk);
      check_rsp(0, acc0, row_p0[n]);
      check_rsp(1, acc1, row_p1[n]);
      if (acc0) begin
        pend0  = 1'b0;
        p0_vld = 1'b0;
      end
      if (acc1) begin
        pend1  = 1'b0;
        p1_vld = 1'b0;
      end
    end while (pend0 || pend1);
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    drive_req(0, IDLE);
    drive_req(1, IDLE);
    exp_last = own_p1;
    // idle after reset, then port 0 wins the first contest
    add_row(IDLE, IDLE);
    add_row(IDLE, IDLE);
    add_row(write_req(0, 10'h100, 4'hF, 32'h1111_0000), write_req(1, 10'h104, 4'hF, 32'h2222));
    // full word, read back from both ports
    add_row(write_req(0, 10'h010, 4'hF, 32'hA5A5_1234), IDLE);
    add_row(read_req(0, 10'h010, 4'hF), IDLE);
    add_row(IDLE, read_req(1, 10'h010, 4'hF));
    // partial lanes merge into the old word
    add_row(write_req(0, 10'h010, 4'b0101, 32'hFFEE_DDCC), IDLE);
    add_row(read_req(0, 10'h010, 4'b0110), IDLE);
    add_row(IDLE, read_req(1, 10'h010, 4'hF));
    // write from the read-only port
    add_row(write_req(0, 10'h020, 4'hF, 32'h0BAD_F00D), IDLE);
    add_row(IDLE, write_req(1, 10'h020, 4'hF, 32'hDEAD_BEEF));
    add_row(read_req(0, 10'h020, 4'hF), IDLE);
    // both ports every row, grants alternate
    add_row(read_req(0, 10'h010, 4'hF), read_req(1, 10'h020, 4'hF));
    add_row(write_req(0, 10'h030, 4'hF, 32'h3333_4444), read_req(1, 10'h100, 4'hF));
    add_row(read_req(0, 10'h100, 4'b1100), read_req(1, 10'h030, 4'hF));
    // random words, read back in reverse order
    rnd_base = 8'($random(seed));
    for (int k = 0; k < N_RND; k++) begin
      rnd_adr[k] = {rnd_base + 8'(11 * k), 2'b00};
      add_row(write_req(0, rnd_adr[k], 4'hF, dat_t'($random(seed))), IDLE);
    end
    for (int k = N_RND - 1; k > 0; k -= 2) begin
      add_row(read_req(0, rnd_adr[k], 4'hF), read_req(1, rnd_adr[k-1], 4'hF));
    end
    cycle_limit = 4 * row_p0.size() + 8 + 20;

    wait (rst_n === 1'b1);
    @(negedge tcb_clk);
    for (int n = 0; n < row_p0.size(); n++) begin
      apply_row(n);
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== sources.f ====
design/tcb_pkg.sv
design/tcb_if.sv
design/tcb_arbiter.sv
design/tcb_memory.sv
design/tcb_mem_subsys.sv
verification/tb_clock.sv
verification/tb_tcb_mem_subsys.sv

// ==== Makefile ====
# Verilator build and run for the TCB memory subsystem

TOP := tb_tcb_mem_subsys

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f sources.f -o sim

# pass only when the pass message shows up in the output
run: build
	@out="$$(./obj_dir/sim 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

lint:
	verilator --lint-only --timing -Wall --top-module tcb_mem_subsys -f sources.f

clean:
	rm -rf obj_dir
